// File: Makefile
TOP := flow_control_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f design/*.sv design/*.svh test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// File: design/branch_arbiter.sv
// Branch arbiter: passes the lowest-numbered branch that jumps
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module branch_arbiter (
    input  flow_control_pkg::branch_result_t results [`FC_BRANCH_COUNT],
    output flow_control_pkg::branch_result_t chosen
);

    // Set once a jumping branch has been taken in the scan
    logic found;

    // ----------------------------------------------------------------------
    // Fixed priority, index 0 first

    always_comb begin
        // No jump at all gives an all-zero result
        chosen = '0;
        found  = 1'b0;
        for (int i = 0; i < `FC_BRANCH_COUNT; i++) begin
            // Higher indices are ignored once a winner exists
            if (!found && results[i].jump) begin
                chosen = results[i];
                found  = 1'b1;
            end
        end
    end

endmodule

// File: design/branch_unit.sv
// Branch unit: per-thread branch entry storage and evaluation against the returning fetch
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module branch_unit #(
    parameter int BRANCH_ID = 0
) (
    input  logic                             clock,
    input  logic                             rst_n,
    input  flow_control_pkg::config_write_t  config_write,
    input  flow_control_pkg::fetch_tag_t     current,
    input  flow_control_pkg::flags_t         flags_previous,
    output flow_control_pkg::branch_result_t result
);
    import flow_control_pkg::*;

    localparam logic [`FC_BRANCH_WIDTH-1:0] MY_BRANCH = `FC_BRANCH_WIDTH'(BRANCH_ID);

    // ----------------------------------------------------------------------
    // Per-thread entry

    logic [`FC_PC_WIDTH-1:0] origin      [`FC_THREAD_COUNT];
    logic [`FC_PC_WIDTH-1:0] destination [`FC_THREAD_COUNT];
    cond_t                   condition   [`FC_THREAD_COUNT];
    logic                    annul       [`FC_THREAD_COUNT];

    logic  selected;
    cond_t cond_now;
    logic  origin_match;
    logic  cond_true;
    logic  jump;

    // Store addressed to this unit
    assign selected = config_write.wren && (config_write.branch == MY_BRANCH);

    // Origin and destination words
    always_ff @(posedge clock) begin
        if (selected) begin
            case (config_write.field)
                `FC_FIELD_ORIGIN:
                    origin[config_write.thread] <= config_write.data[`FC_PC_WIDTH-1:0];
                `FC_FIELD_DEST:
                    destination[config_write.thread] <= config_write.data[`FC_PC_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Control word; condition never keeps the unit quiet until programmed
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FC_THREAD_COUNT; i++) begin
                condition[i] <= cond_never;
                annul[i]     <= 1'b0;
            end
        end else if (selected && (config_write.field == `FC_FIELD_CTRL)) begin
            condition[config_write.thread] <=
                cond_t'(config_write.data[`FC_COND_MSB:`FC_COND_LSB]);
            annul[config_write.thread] <= config_write.data[`FC_ANNUL_BIT];
        end
    end

    // ----------------------------------------------------------------------
    // Evaluation for the thread whose instruction just came back

    always_comb begin
        cond_now     = condition[current.thread];
        origin_match = (origin[current.thread] == current.pc);
        case (cond_now)
            cond_always:       cond_true = 1'b1;
            cond_zero:         cond_true = flags_previous.zero;
            cond_not_zero:     cond_true = !flags_previous.zero;
            cond_negative:     cond_true = flags_previous.negative;
            cond_not_negative: cond_true = !flags_previous.negative;
            cond_carry:        cond_true = flags_previous.carry;
            cond_overflow:     cond_true = flags_previous.overflow;
            default:           cond_true = 1'b0;
        endcase
        jump = origin_match && cond_true && (cond_now != cond_never);
    end

    assign result.jump        = jump;
    // Annul only matters when the branch is taken
    assign result.cancel      = jump && annul[current.thread];
    assign result.destination = destination[current.thread];

endmodule

// File: design/config_decoder.sv
// Config decoder: gates config stores and splits the address into branch, thread and field
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module config_decoder (
    input  logic                            config_strobe,
    input  logic                            cancel_current,
    input  logic [`FC_ADDR_WIDTH-1:0]       config_addr,
    input  logic [`FC_WORD_WIDTH-1:0]       config_data,
    output flow_control_pkg::config_write_t config_write
);

    // Address window, all kept at address width
    localparam logic [`FC_ADDR_WIDTH-1:0] BASE    = `FC_CONFIG_BASE;
    localparam logic [`FC_ADDR_WIDTH-1:0] BOUND   = BASE + `FC_ADDR_WIDTH'(`FC_CONFIG_SPAN - 1);
    localparam logic [`FC_ADDR_WIDTH-1:0] ENTRIES = `FC_ADDR_WIDTH'(`FC_CONFIG_ENTRIES);
    localparam logic [`FC_ADDR_WIDTH-1:0] THREADS = `FC_ADDR_WIDTH'(`FC_THREAD_COUNT);

    logic                      in_range;
    logic [`FC_ADDR_WIDTH-1:0] offset;
    // Index of the branch/thread entry, before the field split
    logic [`FC_ADDR_WIDTH-1:0] entry;

    always_comb begin
        in_range = (config_addr >= BASE) && (config_addr <= BOUND);
        offset   = config_addr - BASE;
        entry    = offset / ENTRIES;
    end

    // Store must be live, not annulled, and land inside our window
    assign config_write.wren   = config_strobe && !cancel_current && in_range;
    assign config_write.branch = `FC_BRANCH_WIDTH'(entry / THREADS);
    assign config_write.thread = `FC_THREAD_WIDTH'(entry % THREADS);
    assign config_write.field  = `FC_FIELD_WIDTH'(offset % ENTRIES);
    assign config_write.data   = config_data;

    // No branch unit decodes a fourth field
    always_comb begin
        if (config_write.wren) begin
            assert (config_write.field <= `FC_FIELD_CTRL)
                else $error("config_decoder: field %0d out of range", config_write.field);
        end
    end

endmodule

// File: design/delay_line.sv
// Delay line: fixed-depth shift register for any packed payload type
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clock,
    input  logic rst_n,
    input  T     in,
    output T     out
);

    T stages [DEPTH];

    // Stage 0 takes the input, the rest shift one place per clock
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[DEPTH-1];

endmodule

// File: design/flow_control.sv
// Flow control: issues per-thread PCs and applies programmed branches to returning fetches
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module flow_control (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        config_strobe,
    input  logic                        cancel_current,
    input  logic [`FC_ADDR_WIDTH-1:0]   config_addr,
    input  logic [`FC_WORD_WIDTH-1:0]   config_data,
    input  flow_control_pkg::flags_t    flags_previous,
    output logic [`FC_PC_WIDTH-1:0]     pc,
    output logic [`FC_THREAD_WIDTH-1:0] thread,
    output logic                        cancel
);
    import flow_control_pkg::*;

    config_write_t  config_write;
    // Tag going out to fetch, and the same tag coming back
    fetch_tag_t     issued;
    fetch_tag_t     current;
    branch_result_t results [`FC_BRANCH_COUNT];
    branch_result_t chosen;

    // ----------------------------------------------------------------------
    // Config path

    config_decoder u_decoder (
        .config_strobe  (config_strobe),
        .cancel_current (cancel_current),
        .config_addr    (config_addr),
        .config_data    (config_data),
        .config_write   (config_write)
    );

    // ----------------------------------------------------------------------
    // Parallel branch units, all looking at the returning tag

    for (genvar b = 0; b < `FC_BRANCH_COUNT; b++) begin : g_branch
        branch_unit #(
            .BRANCH_ID (b)
        ) u_branch (
            .clock          (clock),
            .rst_n          (rst_n),
            .config_write   (config_write),
            .current        (current),
            .flags_previous (flags_previous),
            .result         (results[b])
        );
    end

    branch_arbiter u_arbiter (
        .results (results),
        .chosen  (chosen)
    );

    // ----------------------------------------------------------------------
    // PC issue and fetch pipe

    pc_controller u_controller (
        .clock   (clock),
        .rst_n   (rst_n),
        .current (current),
        .chosen  (chosen),
        .issued  (issued)
    );

    // Keeps each PC aligned with its fetched instruction
    delay_line #(
        .T     (fetch_tag_t),
        .DEPTH (`FC_FETCH_DEPTH)
    ) u_fetch_pipe (
        .clock (clock),
        .rst_n (rst_n),
        .in    (issued),
        .out   (current)
    );

    assign pc     = issued.pc;
    assign thread = issued.thread;
    // Annuls the instruction after the taken branch
    assign cancel = chosen.cancel;

endmodule

// File: design/flow_control_defs.svh
// Flow control widths, counts and config address map
`ifndef FLOW_CONTROL_DEFS_SVH
`define FLOW_CONTROL_DEFS_SVH

// ----------------------------------------------------------------------
// Program counter and threads

`define FC_PC_WIDTH        10
// Stages between PC issue and the instruction coming back
`define FC_FETCH_DEPTH     3
// One thread in flight per fetch stage, plus the one being issued
`define FC_THREAD_COUNT    (`FC_FETCH_DEPTH + 1)
`define FC_THREAD_WIDTH    2

// ----------------------------------------------------------------------
// Branch units and config bus

`define FC_BRANCH_COUNT    4
`define FC_BRANCH_WIDTH    2
`define FC_ADDR_WIDTH      10
`define FC_WORD_WIDTH      16

// Config words start here, laid out as branch, then thread, then field
`define FC_CONFIG_BASE     10'h200
`define FC_CONFIG_ENTRIES  3
`define FC_CONFIG_SPAN     (`FC_BRANCH_COUNT * `FC_THREAD_COUNT * `FC_CONFIG_ENTRIES)

// Field selector within one branch/thread entry
`define FC_FIELD_WIDTH     2
`define FC_FIELD_ORIGIN    2'd0
`define FC_FIELD_DEST      2'd1
`define FC_FIELD_CTRL      2'd2

// Layout of the control word
`define FC_COND_MSB        2
`define FC_COND_LSB        0
`define FC_ANNUL_BIT       3

`endif

// File: design/flow_control_pkg.sv
// Shared types for the flow control block and its branch units
`include "flow_control_defs.svh"

package flow_control_pkg;

    // ALU flags of the previous instruction
    // R zero and sign tests already folded into zero and negative
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } flags_t;

    // Branch condition, as stored in bits 2..0 of the control word
    typedef enum logic [2:0] {
        cond_never        = 3'd0,
        cond_always       = 3'd1,
        cond_zero         = 3'd2,
        cond_not_zero     = 3'd3,
        cond_negative     = 3'd4,
        cond_not_negative = 3'd5,
        cond_carry        = 3'd6,
        cond_overflow     = 3'd7
    } cond_t;

    // Thread and PC of one fetch, carried down the fetch pipe
    typedef struct packed {
        logic [`FC_THREAD_WIDTH-1:0] thread;
        logic [`FC_PC_WIDTH-1:0]     pc;
    } fetch_tag_t;

    // Decision of one branch unit, or the arbitrated winner
    typedef struct packed {
        logic                    jump;
        logic                    cancel;
        logic [`FC_PC_WIDTH-1:0] destination;
    } branch_result_t;

    // Decoded config store, broadcast to every branch unit
    typedef struct packed {
        logic                        wren;
        logic [`FC_BRANCH_WIDTH-1:0] branch;
        logic [`FC_THREAD_WIDTH-1:0] thread;
        logic [`FC_FIELD_WIDTH-1:0]  field;
        logic [`FC_WORD_WIDTH-1:0]   data;
    } config_write_t;

endpackage

// File: design/pc_controller.sv
// PC controller: round-robin thread issue and per-thread PC table update
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module pc_controller (
    input  logic                             clock,
    input  logic                             rst_n,
    input  flow_control_pkg::fetch_tag_t     current,
    input  flow_control_pkg::branch_result_t chosen,
    output flow_control_pkg::fetch_tag_t     issued
);

    localparam logic [`FC_THREAD_WIDTH-1:0] LAST_THREAD =
        `FC_THREAD_WIDTH'(`FC_THREAD_COUNT - 1);
    localparam int                          FILL_WIDTH  = $clog2(`FC_FETCH_DEPTH + 1);
    localparam logic [FILL_WIDTH-1:0]       FILL_DONE   = FILL_WIDTH'(`FC_FETCH_DEPTH);

    logic [`FC_THREAD_WIDTH-1:0] counter;
    logic [`FC_THREAD_WIDTH-1:0] next_thread;
    logic [`FC_PC_WIDTH-1:0]     pc_table [`FC_THREAD_COUNT];
    logic [`FC_PC_WIDTH-1:0]     next_pc;
    // Cycles since reset, saturating once the fetch pipe holds real tags
    logic [FILL_WIDTH-1:0]       fill_count;

    // ----------------------------------------------------------------------
    // Issue side

    assign next_thread = (counter == LAST_THREAD) ? '0 : counter + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            counter <= '0;
        end else begin
            counter <= next_thread;
        end
    end

    assign issued.thread = counter;
    assign issued.pc     = pc_table[counter];

    // ----------------------------------------------------------------------
    // Return side

    // Taken branch wins, else fall through (wraps at 1023)
    assign next_pc = chosen.jump ? chosen.destination : current.pc + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FC_THREAD_COUNT; i++) begin
                pc_table[i] <= '0;
            end
        end else begin
            pc_table[current.thread] <= next_pc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fill_count <= '0;
        end else if (fill_count != FILL_DONE) begin
            fill_count <= fill_count + 1'b1;
        end
    end

    // Returning thread is the one issued next, so its update is seen in time
    a_thread_in_step: assert property (
        @(posedge clock) disable iff (!rst_n)
        (fill_count == FILL_DONE) |-> (current.thread == next_thread)
    ) else $error("pc_controller: returning thread %0d, next issue %0d",
                  current.thread, next_thread);

endmodule

// File: list.f
+incdir+design
design/flow_control_pkg.sv
design/config_decoder.sv
design/branch_unit.sv
design/branch_arbiter.sv
design/pc_controller.sv
design/delay_line.sv
design/flow_control.sv
test/clock_gen.sv
test/flow_control_tb.sv

// File: test/clock_gen.sv
// Clock and reset generator for the flow control testbench
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// File: test/flow_control_cases.txt
# C addr data cancel : config store, all hex, one cycle each
# R flags count : run with flags {zero,negative,carry,overflow} hex, count decimal
R 0 16
# Thread 1: branch 0 always at 10 to 2, annul
C 203 00A 0
C 204 002 0
C 205 009 0
# Thread 2: branch 0 carry at 8 to 20 annul, branch 1 zero at 8 to 30
C 206 008 0
C 207 014 0
C 208 00E 0
C 212 008 0
C 213 01E 0
C 214 002 0
# Thread 0: branch 1 overflow at 25 to 35 annul, branch 2 not_zero at 20 to 3
C 20C 019 0
C 20D 023 0
C 20E 00F 0
C 218 014 0
C 219 003 0
C 21A 003 0
# Thread 3: branch 2 negative at 12 to 1022, wraps to 0
C 221 00C 0
C 222 3FE 0
C 223 004 0
# Branch 3 loops threads 0, 2 and 3 from 40 back to 0
C 224 028 0
C 225 000 0
C 226 001 0
C 22A 028 0
C 22B 000 0
C 22C 001 0
C 22D 028 0
C 22E 000 0
C 22F 001 0
# Annulled store and stores outside the window
C 211 001 1
C 230 001 0
C 1FF 001 0
R 0 60
R 8 80
R 4 80
R 2 80
R 1 80
R A 80
R F 120
R 0 40

// File: test/flow_control_tb.sv
// Testbench for the flow control block that replays the cases file against a reference model
`timescale 1ns/1ps
`include "flow_control_defs.svh"

module flow_control_tb;
    import flow_control_pkg::*;

    logic                        clock;
    logic                        rst_n;
    logic                        config_strobe;
    logic                        cancel_current;
    logic [`FC_ADDR_WIDTH-1:0]   config_addr;
    logic [`FC_WORD_WIDTH-1:0]   config_data;
    flags_t                      flags_previous;
    logic [`FC_PC_WIDTH-1:0]     pc;
    logic [`FC_THREAD_WIDTH-1:0] thread;
    logic                        cancel;

    // Parsed case lines
    byte kind_q[$];
    int  arg_a_q[$];
    int  arg_b_q[$];
    int  arg_c_q[$];
    bit  loaded;

    // Reference model state
    int  table_pc [4];
    int  pipe_thread [3];
    int  pipe_pc [3];
    int  counter;
    int  cfg_origin [4][4];
    int  cfg_dest [4][4];
    int  cfg_cond [4][4];
    int  cfg_annul [4][4];

    clock_gen u_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    flow_control u_dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .config_strobe  (config_strobe),
        .cancel_current (cancel_current),
        .config_addr    (config_addr),
        .config_data    (config_data),
        .flags_previous (flags_previous),
        .pc             (pc),
        .thread         (thread),
        .cancel         (cancel)
    );

    // ------------------------------------------------------------------
    // Compare tasks

    task automatic check_pc(input logic [`FC_PC_WIDTH-1:0] got,
                            input logic [`FC_PC_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: pc is %0d, expected %0d", $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_thread(input logic [`FC_THREAD_WIDTH-1:0] got,
                                input logic [`FC_THREAD_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: thread is %0d, expected %0d", $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "thread mismatch");
        end
    endtask

    task automatic check_cancel(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: cancel is %b, expected %b", $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "cancel mismatch");
        end
    endtask

    // Flag bits zero, negative, carry and overflow from MSB down
    function automatic bit cond_holds(input int cond, input logic [3:0] f);
        case (cond)
            1: return 1'b1;
            2: return f[3];
            3: return !f[3];
            4: return f[2];
            5: return !f[2];
            6: return f[1];
            7: return f[0];
            default: return 1'b0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // One clock of stimulus, check and model update

    task automatic run_cycle(input bit strobe, input int addr, input int data,
                             input bit annulled, input logic [3:0] flags);
        int  dt;
        int  dpc;
        int  off;
        int  b;
        int  t;
        bit  jump;
        bit  exp_cancel;
        int  next_pc;
        config_strobe  = strobe;
        config_addr    = addr[`FC_ADDR_WIDTH-1:0];
        config_data    = data[`FC_WORD_WIDTH-1:0];
        cancel_current = annulled;
        flags_previous = flags;
        #1;
        dt         = pipe_thread[2];
        dpc        = pipe_pc[2];
        jump       = 1'b0;
        exp_cancel = 1'b0;
        next_pc    = (dpc + 1) % 1024;
        // Lowest branch index wins
        for (int i = 0; i < 4; i++) begin
            if (!jump && cfg_cond[i][dt] != 0 && cfg_origin[i][dt] == dpc &&
                cond_holds(cfg_cond[i][dt], flags)) begin
                jump       = 1'b1;
                exp_cancel = cfg_annul[i][dt][0];
                next_pc    = cfg_dest[i][dt];
            end
        end
        check_thread(thread, counter[`FC_THREAD_WIDTH-1:0]);
        check_pc(pc, table_pc[counter][`FC_PC_WIDTH-1:0]);
        check_cancel(cancel, exp_cancel);
        // State after the rising edge
        if (strobe && !annulled && addr >= 'h200 && addr < 'h230) begin
            off = addr - 'h200;
            b   = off / 12;
            t   = (off / 3) % 4;
            case (off % 3)
                0: cfg_origin[b][t] = data % 1024;
                1: cfg_dest[b][t] = data % 1024;
                default: begin
                    cfg_cond[b][t]  = data & 7;
                    cfg_annul[b][t] = (data >> 3) & 1;
                end
            endcase
        end
        pipe_thread[2] = pipe_thread[1];
        pipe_pc[2]     = pipe_pc[1];
        pipe_thread[1] = pipe_thread[0];
        pipe_pc[1]     = pipe_pc[0];
        pipe_thread[0] = counter;
        pipe_pc[0]     = table_pc[counter];
        table_pc[dt]   = next_pc;
        counter        = (counter + 1) % 4;
        @(negedge clock);
    endtask

    // ------------------------------------------------------------------
    // Case file reader

    task automatic load_cases();
        int    fd;
        int    a;
        int    b;
        int    c;
        string line;
        fd = $fopen("test/flow_control_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file test/flow_control_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "no cases file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            if (line.getc(0) == "C") begin
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
            end else begin
                void'($sscanf(line.substr(1, line.len() - 1), "%h %d", a, b));
                c = 0;
            end
            kind_q.push_back(line.getc(0));
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
            arg_c_q.push_back(c);
        end
        $fclose(fd);
    endtask

    // Watchdog sized from the number of case lines
    initial begin
        wait (loaded);
        repeat (kind_q.size() * 20 + 100) @(posedge clock);
        $display("Simulation ran past its time limit without finishing");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        config_strobe  = 1'b0;
        cancel_current = 1'b0;
        config_addr    = '0;
        config_data    = '0;
        flags_previous = '0;
        loaded         = 1'b0;
        counter        = 0;
        for (int i = 0; i < 4; i++) begin
            table_pc[i] = 0;
            for (int j = 0; j < 4; j++) begin
                cfg_origin[i][j] = 0;
                cfg_dest[i][j]   = 0;
                cfg_cond[i][j]   = 0;
                cfg_annul[i][j]  = 0;
            end
        end
        for (int i = 0; i < 3; i++) begin
            pipe_thread[i] = 0;
            pipe_pc[i]     = 0;
        end
        load_cases();
        loaded = 1'b1;
        @(posedge rst_n);
        for (int n = 0; n < kind_q.size(); n++) begin
            if (kind_q[n] == "C") begin
                run_cycle(1'b1, arg_a_q[n], arg_b_q[n], arg_c_q[n][0], 4'h0);
            end else begin
                repeat (arg_b_q[n]) run_cycle(1'b0, 0, 0, 1'b0, arg_a_q[n][3:0]);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule
